// ==== common/uart_bridge_defs.svh ====
/*
 * uart register bridge setup
 * serial timing, counter width and register map constants
 */
`ifndef UART_BRIDGE_DEFS_SVH
`define UART_BRIDGE_DEFS_SVH

// system clocks per serial bit, kept small for simulation
`define BRIDGE_CLKS_PER_BIT 16
`define BRIDGE_CNT_W 16 // bit period counter width

`define BRIDGE_REG_COUNT 8 // registers in the bank
`define BRIDGE_REG_AW 3 // index bits into the bank
`define BRIDGE_LED_ADDR 0 // register mirrored on led
`define BRIDGE_BAD_ADDR_DATA 8'hEE // read reply for an address out of range

`endif

// ==== common/uart_bridge_pkg.sv ====
/*
 * uart register bridge types
 * byte strobes between the serial blocks and the command word views
 */
package uart_bridge_pkg;

	// byte out of the receiver, strobes never high together
	typedef struct packed {
		logic [7:0] data;
		logic       valid;     // good stop bit
		logic       frame_err; // stop bit sampled low
	} rx_byte_t;

	// request into the transmitter
	typedef struct packed {
		logic [7:0] data;
		logic       start; // only while tx_busy is low
	} tx_req_t;

	// header byte layout
	typedef struct packed {
		logic       wr;   // set for write, a data byte follows
		logic [6:0] addr;
	} cmd_hdr_t;

	/*
	 * one received byte, read as a header while waiting for a command
	 * and as plain write data after a write header
	 */
	typedef union packed {
		cmd_hdr_t   hdr;
		logic [7:0] raw;
	} cmd_word_u;

endpackage

// ==== uart_rx/uart_rx.sv ====
/*
 * uart receiver
 * 8N1, samples each bit mid-period and checks the stop bit
 */
`timescale 1ns/10ps
`include "uart_bridge_defs.svh"

module uart_rx
	import uart_bridge_pkg::*;
(
	input  logic     sys_clk,
	input  logic     sys_rst_n,
	input  logic     rx,
	output rx_byte_t rx_byte
);

	localparam int CNT_W = `BRIDGE_CNT_W;
	localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(`BRIDGE_CLKS_PER_BIT - 1);
	localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(`BRIDGE_CLKS_PER_BIT / 2 - 1);

	typedef enum logic [1:0] {
		S_IDLE,
		S_START,
		S_DATA,
		S_STOP
	} state_t;

	state_t           state;
	logic             rx_meta;
	logic             rx_sync;
	logic [CNT_W-1:0] clk_cnt;
	logic [2:0]       bit_idx;
	logic [7:0]       shift_reg;
	logic             valid_q;
	logic             err_q;

	// two flop synchronizer, line idles high
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state   <= S_IDLE;
			clk_cnt <= '0;
			bit_idx <= '0;
			valid_q <= 1'b0;
			err_q   <= 1'b0;
		end else begin
			valid_q <= 1'b0; // strobes
			err_q   <= 1'b0;
			case (state)
				S_IDLE: begin
					clk_cnt <= '0;
					bit_idx <= '0;
					if (!rx_sync)
						state <= S_START; // falling edge
				end
				S_START: begin
					if (clk_cnt == HALF_LAST) begin
						clk_cnt <= '0;
						state   <= rx_sync ? S_IDLE : S_DATA; // high here is a glitch
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				S_DATA: begin
					if (clk_cnt == BIT_LAST) begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= S_STOP;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				S_STOP: begin
					if (clk_cnt == BIT_LAST) begin
						// mid stop bit, no wait for its end
						clk_cnt <= '0;
						valid_q <= rx_sync;
						err_q   <= !rx_sync;
						state   <= S_IDLE;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// lsb arrives first, shift in from the top
	always_ff @(posedge sys_clk) begin
		if (state == S_DATA && clk_cnt == BIT_LAST)
			shift_reg <= {rx_sync, shift_reg[7:1]};
	end

	assign rx_byte = '{data: shift_reg, valid: valid_q, frame_err: err_q};

endmodule

// ==== hdl/cmd_parser.sv ====
/*
 * command parser and register bank
 * decodes write and read headers, holds one reply for the transmitter
 */
`timescale 1ns/10ps
`include "uart_bridge_defs.svh"

module cmd_parser
	import uart_bridge_pkg::*;
(
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  rx_byte_t   rx_byte,
	input  logic       tx_busy,
	output tx_req_t    tx_req,
	output logic [7:0] led
);

	localparam int AW = `BRIDGE_REG_AW;
	localparam logic [6:0] REG_COUNT = 7'(`BRIDGE_REG_COUNT);

	typedef enum logic {
		S_HDR,
		S_DATA
	} state_t;

	state_t     state;
	cmd_word_u  word;
	logic [6:0] wr_addr;
	logic [7:0] regs [`BRIDGE_REG_COUNT];
	logic [7:0] rd_data;
	logic       rd_hit;
	logic       wr_hit;
	logic [7:0] pend_data;
	logic       pend_valid;
	logic       issue;

	assign word.raw = rx_byte.data;

	assign rd_hit = rx_byte.valid && state == S_HDR && !word.hdr.wr;
	assign wr_hit = rx_byte.valid && state == S_DATA && wr_addr < REG_COUNT;

	assign rd_data = (word.hdr.addr < REG_COUNT) ? regs[word.hdr.addr[AW-1:0]]
	                                             : `BRIDGE_BAD_ADDR_DATA;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			state <= S_HDR;
		else if (rx_byte.frame_err)
			state <= S_HDR; // resync on a broken frame
		else if (rx_byte.valid) begin
			case (state)
				S_HDR:   state <= word.hdr.wr ? S_DATA : S_HDR;
				S_DATA:  state <= S_HDR;
				default: state <= S_HDR;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (rx_byte.valid && state == S_HDR && word.hdr.wr)
			wr_addr <= word.hdr.addr;
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			regs <= '{default: '0};
		else if (wr_hit)
			regs[wr_addr[AW-1:0]] <= word.raw; // out of range writes dropped
	end

	// one reply waits here until the transmitter is free
	assign issue = pend_valid && !tx_busy;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			pend_valid <= 1'b0;
		else if (rd_hit)
			pend_valid <= 1'b1;
		else if (issue)
			pend_valid <= 1'b0;
	end

	always_ff @(posedge sys_clk) begin
		if (rd_hit)
			pend_data <= rd_data;
	end

	assign tx_req = '{data: pend_data, start: issue};
	assign led    = regs[`BRIDGE_LED_ADDR];

endmodule

// ==== uart_tx/uart_tx.sv ====
/*
 * uart transmitter
 * sends one 8N1 frame per start strobe, lsb first
 */
`timescale 1ns/10ps
`include "uart_bridge_defs.svh"

module uart_tx
	import uart_bridge_pkg::*;
(
	input  logic    sys_clk,
	input  logic    sys_rst_n,
	input  tx_req_t tx_req,
	output logic    tx,
	output logic    tx_busy
);

	localparam int CNT_W = `BRIDGE_CNT_W;
	localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(`BRIDGE_CLKS_PER_BIT - 1);
	localparam logic [3:0] FRAME_LAST = 4'd9; // start, 8 data, stop

	logic [9:0]       frame;
	logic [CNT_W-1:0] clk_cnt;
	logic [3:0]       bit_cnt;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			frame   <= '1; // line high
			tx_busy <= 1'b0;
			clk_cnt <= '0;
			bit_cnt <= '0;
		end else if (!tx_busy) begin
			clk_cnt <= '0;
			bit_cnt <= '0;
			if (tx_req.start) begin
				frame   <= {1'b1, tx_req.data, 1'b0};
				tx_busy <= 1'b1;
			end
		end else if (clk_cnt == BIT_LAST) begin
			// next bit, ones fill in behind the stop bit
			clk_cnt <= '0;
			frame   <= {1'b1, frame[9:1]};
			bit_cnt <= bit_cnt + 1'b1;
			if (bit_cnt == FRAME_LAST)
				tx_busy <= 1'b0;
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

	assign tx = frame[0];

endmodule

// ==== hdl/uart_bridge_top.sv ====
/*
 * uart register bridge top level
 * receiver into parser, parser replies through the transmitter
 */
`timescale 1ns/10ps

module uart_bridge_top
	import uart_bridge_pkg::*;
(
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       rx,
	output logic       tx,
	output logic       frame_err,
	output logic [7:0] led
);

	rx_byte_t rx_byte;
	tx_req_t  tx_req;
	logic     tx_busy;

	uart_rx u_uart_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx        (rx),
		.rx_byte   (rx_byte)
	);

	cmd_parser u_cmd_parser (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_byte   (rx_byte),
		.tx_busy   (tx_busy),
		.tx_req    (tx_req),
		.led       (led)
	);

	uart_tx u_uart_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_req    (tx_req),
		.tx        (tx),
		.tx_busy   (tx_busy)
	);

	assign frame_err = rx_byte.frame_err; // bad stop bit pulse

endmodule

// ==== sim/uart_bridge_tb.sv ====
/*
 * uart register bridge testbench
 * directed serial tests checked against a register model
 */
`timescale 1ns/10ps
`include "uart_bridge_defs.svh"

module uart_bridge_tb;

	localparam int CPB = `BRIDGE_CLKS_PER_BIT;
	localparam int WAIT_LIMIT = 30 * CPB; // cycles allowed for one wait

	logic        sys_clk;
	logic        sys_rst_n;
	logic        rx;
	logic        tx;
	logic        frame_err;
	logic [7:0]  led;
	logic [7:0]  model [`BRIDGE_REG_COUNT];
	logic [31:0] lfsr_state;

	uart_bridge_top UUT (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx        (rx),
		.tx        (tx),
		.frame_err (frame_err),
		.led       (led)
	);

	initial begin
		sys_clk = 1'b0;
		forever #4 sys_clk = ~sys_clk;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_val(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			fail_run($sformatf("Error: %s is 0x%02h, expected 0x%02h", name, got, exp));
	endtask

	// galois form, taps 32,22,2,1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic rand_byte(output logic [7:0] b);
		for (int i = 0; i < 8; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			b[i[2:0]] = lfsr_state[0]; // one step per bit
		end
	endtask

	// one bit period on rx, changed on the falling edge
	task automatic drive_bit(input logic b);
		@(negedge sys_clk);
		rx = b;
		repeat (CPB - 1) @(negedge sys_clk);
	endtask

	task automatic idle_bits(input int n);
		repeat (n) drive_bit(1'b1);
	endtask

	task automatic send_byte(input logic [7:0] data, input logic bad_stop);
		drive_bit(1'b0);
		for (int i = 0; i < 8; i++)
			drive_bit(data[i[2:0]]);
		drive_bit(!bad_stop); // low stop bit breaks the frame
	endtask

	task automatic recv_byte(output logic [7:0] b);
		int waited;
		waited = 0;
		@(negedge sys_clk);
		while (tx !== 1'b0) begin
			if (waited >= WAIT_LIMIT)
				fail_run("timed out waiting for a start bit on tx");
			waited++;
			@(negedge sys_clk);
		end
		repeat (CPB / 2) @(negedge sys_clk); // middle of start bit
		check_val("tx start bit", 8'(tx), 8'h00);
		for (int i = 0; i < 8; i++) begin
			repeat (CPB) @(negedge sys_clk);
			b[i[2:0]] = tx;
		end
		repeat (CPB) @(negedge sys_clk);
		check_val("tx stop bit", 8'(tx), 8'h01);
	endtask

	task automatic wait_frame_err();
		int waited;
		waited = 0;
		@(negedge sys_clk);
		while (frame_err !== 1'b1) begin
			if (waited >= WAIT_LIMIT)
				fail_run("frame_err never pulsed after a frame with a low stop bit");
			waited++;
			@(negedge sys_clk);
		end
	endtask

	task automatic write_reg(input logic [6:0] addr, input logic [7:0] data);
		send_byte({1'b1, addr}, 1'b0);
		send_byte(data, 1'b0);
	endtask

	// reply starts before the header's stop bit ends
	task automatic read_reg(input logic [6:0] addr, output logic [7:0] data);
		fork
			send_byte({1'b0, addr}, 1'b0);
			recv_byte(data);
		join
	endtask

	task automatic read_check(input logic [6:0] addr, input logic [7:0] exp);
		logic [7:0] got;
		read_reg(addr, got);
		check_val($sformatf("reply for address %0d", addr), got, exp);
	endtask

	task automatic test_reset();
		check_val("led", led, 8'h00);
		repeat (20 * CPB) begin
			@(negedge sys_clk);
			check_val("tx", 8'(tx), 8'h01);
			check_val("frame_err", 8'(frame_err), 8'h00);
		end
	endtask

	task automatic test_write_read();
		logic [7:0] d;
		for (int i = 0; i < `BRIDGE_REG_COUNT; i++) begin
			rand_byte(d);
			write_reg(7'(i), d);
			model[i[2:0]] = d;
		end
		for (int i = 0; i < `BRIDGE_REG_COUNT; i++)
			read_check(7'(i), model[i[2:0]]);
		check_val("led", led, model[0]);
	endtask

	task automatic test_out_of_range();
		logic [7:0] d;
		read_check(7'd9, `BRIDGE_BAD_ADDR_DATA);
		rand_byte(d);
		write_reg(7'd20, d); // must not land anywhere
		for (int i = 0; i < `BRIDGE_REG_COUNT; i++)
			read_check(7'(i), model[i[2:0]]);
		check_val("led", led, model[0]);
	endtask

	task automatic test_frame_err();
		// good write header, then a broken frame while the parser waits for data
		send_byte({1'b1, 7'd5}, 1'b0);
		fork
			send_byte({1'b0, 7'd2}, 1'b1);
			wait_frame_err();
		join
		idle_bits(2);
		read_check(7'd2, model[2]); // a parser still waiting for data sends no reply
		read_check(7'd5, model[5]);
	endtask

	task automatic test_back_to_back();
		logic [6:0] order [8];
		for (int i = 0; i < 8; i++)
			order[i[2:0]] = 7'((i * 3) % 8);
		fork
			begin
				for (int s = 0; s < 8; s++)
					send_byte({1'b0, order[s[2:0]]}, 1'b0); // no idle between frames
			end
			begin
				logic [7:0] got;
				for (int r = 0; r < 8; r++) begin
					recv_byte(got);
					check_val("back to back reply", got, model[order[r[2:0]][2:0]]);
				end
			end
		join
	endtask

	initial begin
		sys_rst_n  = 1'b0;
		rx         = 1'b1;
		lfsr_state = 32'h31f2;
		model      = '{default: 8'h00};
		repeat (16) @(negedge sys_clk);
		sys_rst_n = 1'b1;
		test_reset();
		test_write_read();
		test_out_of_range();
		test_frame_err();
		test_back_to_back();
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

// ==== uart_bridge.f ====
+incdir+common
common/uart_bridge_pkg.sv
uart_rx/uart_rx.sv
hdl/cmd_parser.sv
uart_tx/uart_tx.sv
hdl/uart_bridge_top.sv
sim/uart_bridge_tb.sv

// ==== Makefile ====
# Verilator build and run for the uart register bridge

VERILATOR ?= verilator
TOP       ?= uart_bridge_tb
FILELIST  ?= uart_bridge.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= ALL TESTS PASSED

SRCS    := $(filter %.sv %.v,$(shell cat $(FILELIST)))
HDRS    := $(wildcard common/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# status comes from the search for the pass line
run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG); grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
